/* filelist.f */
hdl/regbank_pkg.sv
hdl/regbus_if.sv
hdl/spi_target.sv
hdl/reg_bank.sv
hdl/sr4094_driver.sv
hdl/board_ctrl_top.sv
verif/spi_target_chk.sv
verif/board_ctrl_monitor.sv
verif/tb_board_ctrl.sv

/* Bender.yml */
package:
  name: board_ctrl

sources:
  - hdl/regbank_pkg.sv
  - hdl/regbus_if.sv
  - hdl/spi_target.sv
  - hdl/reg_bank.sv
  - hdl/sr4094_driver.sv
  - hdl/board_ctrl_top.sv
  - target: simulation
    files:
      - verif/spi_target_chk.sv
      - verif/board_ctrl_monitor.sv
      - verif/tb_board_ctrl.sv

/* verif/tb_board_ctrl.sv */
`timescale 1ns/1ns

module tb_board_ctrl;

  localparam int N_DEV = 4;
  // 4094 transfer longer than a frame so close writes hit the pending path
  localparam int SR_DIV = 16;
  localparam logic [31:0] SEED = 32'hab6a2118;
  localparam int N_FRAMES = 300;
  // sclk half period in cs cycles
  localparam int HALF = 6;
  localparam int CLK_NS = 10;
  localparam int DRV_DLY = 2;
  // one transfer in flight plus one pending behind it
  localparam int DRAIN_CYC = 2 * (49 * SR_DIV + 1) + 16;
  localparam longint WATCHDOG_NS = longint'(N_FRAMES) * regbank_pkg::FRAME_BITS
                                   * 2 * HALF * CLK_NS * 2 + DRAIN_CYC * CLK_NS + 20000;

  logic cs;
  logic rst_n;
  logic spi_sclk;
  logic spi_ss_n;
  logic mosi;
  logic miso;
  logic [23:0] led;
  logic [N_DEV-1:0] spi_dev_ss_n;
  logic sr_clk;
  logic sr_data;
  logic sr_strobe;
  logic sr_oe;
  logic final_chk;
  int mon_errors;

  board_ctrl_top #(
    .N_DEV  (N_DEV),
    .SR_DIV (SR_DIV)
  ) board_ctrl_top_inst (
    .cs           (cs),
    .rst_n        (rst_n),
    .spi_sclk     (spi_sclk),
    .spi_ss_n     (spi_ss_n),
    .mosi         (mosi),
    .miso         (miso),
    .led          (led),
    .spi_dev_ss_n (spi_dev_ss_n),
    .sr_clk       (sr_clk),
    .sr_data      (sr_data),
    .sr_strobe    (sr_strobe),
    .sr_oe        (sr_oe)
  );

  board_ctrl_monitor #(
    .N_DEV (N_DEV)
  ) board_ctrl_monitor_inst (
    .cs           (cs),
    .rst_n        (rst_n),
    .spi_sclk     (spi_sclk),
    .spi_ss_n     (spi_ss_n),
    .mosi         (mosi),
    .miso         (miso),
    .led          (led),
    .spi_dev_ss_n (spi_dev_ss_n),
    .sr_clk       (sr_clk),
    .sr_data      (sr_data),
    .sr_strobe    (sr_strobe),
    .sr_oe        (sr_oe),
    .final_chk    (final_chk),
    .error_count  (mon_errors)
  );

  initial
  begin
    cs = 1'b0;
    forever
    begin
      #(CLK_NS / 2) cs = ~cs;
    end
  end

  // n rising edges then the drive offset
  task automatic step(input int n);
    repeat (n) @(posedge cs);
    #DRV_DLY;
  endtask

  // mode 0 frame sent MSB first and cut short when nbits is below 40
  task automatic send_frame(input logic [39:0] word, input int nbits);
    int i;
    spi_ss_n = 1'b0;
    for (i = 0; i < nbits; i++)
    begin
      mosi = word[regbank_pkg::FRAME_BITS-1-i];
      step(HALF);
      spi_sclk = 1'b1;
      step(HALF);
      spi_sclk = 1'b0;
    end
    step(HALF);
    spi_ss_n = 1'b1;
    mosi = 1'b0;
  endtask

  // mostly mapped addresses and small mux values so selects actually decode
  function automatic logic [39:0] random_frame();
    logic rd;
    logic [6:0] addr;
    logic [7:0] pad;
    logic [23:0] data;
    rd = 1'($urandom_range(0, 1));
    addr = ($urandom_range(0, 9) < 8) ? 7'(7 + $urandom_range(0, 2)) : 7'($urandom);
    pad = 8'($urandom);
    data = 24'($urandom);
    if ((addr == regbank_pkg::ADDR_SPI_MUX) && ($urandom_range(0, 1) == 1))
    begin
      data = 24'($urandom_range(0, N_DEV + 1));
    end
    return {rd, addr, pad, data};
  endfunction

  initial
  begin
    int nbits;
    int total;
    int asrt_errors;
    rst_n = 1'b0;
    spi_sclk = 1'b0;
    spi_ss_n = 1'b1;
    mosi = 1'b0;
    final_chk = 1'b0;
    void'($urandom(SEED));
    step(5);
    rst_n = 1'b1;
    step(10);
    for (int f = 0; f < N_FRAMES; f++)
    begin
      // roughly one frame in ten is aborted early
      nbits = ($urandom_range(0, 9) == 0) ? $urandom_range(1, 39) : regbank_pkg::FRAME_BITS;
      send_frame(random_frame(), nbits);
      // short gaps land inside a running 4094 transfer
      step($urandom_range(12, 300));
    end
    step(DRAIN_CYC);
    final_chk = 1'b1;
    step(3);
    asrt_errors = board_ctrl_top_inst.spi_target_inst.spi_target_chk_inst.assert_fails;
    total = mon_errors + asrt_errors;
    $display("errors: %0d monitor, %0d assertion", mon_errors, asrt_errors);
    if (total == 0)
    begin
      $display("Test OK");
    end
    else
    begin
      $display("Test FAILED");
    end
    $finish;
  end

  // watchdog
  initial
  begin
    #(WATCHDOG_NS);
    $display("timeout: the run did not finish within %0d ns", WATCHDOG_NS);
    $display("Test FAILED");
    $finish;
  end

endmodule

/* verif/board_ctrl_monitor.sv */
`timescale 1ns/1ns

module board_ctrl_monitor #(
  parameter int N_DEV = 4
) (
  input  logic cs,
  input  logic rst_n,
  input  logic spi_sclk,
  input  logic spi_ss_n,
  input  logic mosi,
  input  logic miso,
  input  logic [23:0] led,
  input  logic [N_DEV-1:0] spi_dev_ss_n,
  input  logic sr_clk,
  input  logic sr_data,
  input  logic sr_strobe,
  input  logic sr_oe,
  input  logic final_chk,
  output int error_count
);

  // previous pin samples for edge detection
  logic prev_sclk;
  logic prev_ss;
  logic prev_sr_clk;
  logic prev_strobe;
  // frame seen on mosi and answer seen on miso
  logic [39:0] rx_frame;
  logic [39:0] miso_word;
  int bit_cnt;
  // register model
  logic [23:0] m_led;
  logic [23:0] m_mux;
  logic [23:0] m_sr;
  // cycles left until led and selects are compared
  int chk_cnt;
  // 4094 driver model, one transfer running plus at most one waiting
  logic busy;
  logic pend;
  logic strobe_seen;
  logic sr_written;
  logic final_done;
  logic [23:0] xfer_val;
  logic [23:0] sr_cap;
  logic [23:0] last_latched;
  int sr_bits;

  // mux value n enables device n-1 (active low), anything else none
  function automatic logic [N_DEV-1:0] expected_selects(input logic [23:0] mux);
    logic [N_DEV-1:0] sel;
    sel = '1;
    if ((mux >= 1) && (mux <= N_DEV))
    begin
      sel[mux-1] = 1'b0;
    end
    return sel;
  endfunction

  function automatic logic [23:0] read_value(input logic [6:0] addr);
    if (addr == regbank_pkg::ADDR_LED)
    begin
      return m_led;
    end
    if (addr == regbank_pkg::ADDR_SPI_MUX)
    begin
      return m_mux;
    end
    if (addr == regbank_pkg::ADDR_4094)
    begin
      return m_sr;
    end
    return regbank_pkg::UNMAPPED_READ;
  endfunction

  task automatic report(input string name, input logic [39:0] exp, input logic [39:0] act);
    error_count++;
    $display("error: %s expected %h got %h at %0t ns", name, exp, act, $time);
  endtask

  // complete 40-bit frame, check the read-back and apply a write
  task automatic commit_frame();
    regbank_pkg::frame_u fr;
    logic [39:0] exp_miso;
    fr.raw = rx_frame;
    // header and pad bits read as zero, write frames too
    exp_miso = '0;
    if (fr.f.rd)
    begin
      exp_miso[23:0] = read_value(fr.f.addr);
    end
    if (miso_word !== exp_miso)
    begin
      report("miso", exp_miso, miso_word);
    end
    if (!fr.f.rd)
    begin
      if (fr.f.addr == regbank_pkg::ADDR_LED)
      begin
        m_led = fr.f.data;
      end
      else if (fr.f.addr == regbank_pkg::ADDR_SPI_MUX)
      begin
        m_mux = fr.f.data;
      end
      else if (fr.f.addr == regbank_pkg::ADDR_4094)
      begin
        m_sr = fr.f.data;
        sr_written = 1'b1;
        if (!busy)
        begin
          busy = 1'b1;
          xfer_val = fr.f.data;
        end
        else
        begin
          pend = 1'b1;
        end
      end
    end
  endtask

  // everything sampled mid-cycle, away from the driving edges
  always @(negedge cs)
  begin
    if (!rst_n)
    begin
      error_count = 0;
      bit_cnt = 0;
      m_led = regbank_pkg::LED_RESET;
      m_mux = '0;
      m_sr = '0;
      // reset values checked on the first cycle out of reset
      chk_cnt = 1;
      busy = 1'b0;
      pend = 1'b0;
      strobe_seen = 1'b0;
      sr_written = 1'b0;
      final_done = 1'b0;
      sr_bits = 0;
      sr_cap = '0;
      last_latched = '0;
    end
    else
    begin
      if (prev_ss && !spi_ss_n)
      begin
        bit_cnt = 0;
        rx_frame = '0;
        miso_word = '0;
      end
      // mosi and miso both taken on rising sclk
      if (!spi_ss_n && spi_sclk && !prev_sclk)
      begin
        rx_frame = {rx_frame[38:0], mosi};
        miso_word = {miso_word[38:0], miso};
        bit_cnt++;
      end
      if (!prev_ss && spi_ss_n)
      begin
        // frames of any other length are dropped
        if (bit_cnt == regbank_pkg::FRAME_BITS)
        begin
          commit_frame();
        end
        chk_cnt = 8;
      end
      // 4094 chain shifts on rising sr_clk
      if (sr_clk && !prev_sr_clk)
      begin
        sr_cap = {sr_cap[22:0], sr_data};
        sr_bits++;
      end
      if (sr_strobe && !prev_strobe)
      begin
        if (!busy)
        begin
          error_count++;
          $display("sr_strobe pulsed with no 4094 write outstanding at %0t ns", $time);
        end
        if (sr_bits != 24)
        begin
          error_count++;
          $display("4094 transfer shifted %0d bits instead of 24 at %0t ns", sr_bits, $time);
        end
        if (sr_cap !== xfer_val)
        begin
          report("sr_data", 40'(xfer_val), 40'(sr_cap));
        end
        last_latched = sr_cap;
        sr_bits = 0;
      end
      // end of strobe, a waiting write starts with the newest value
      if (!sr_strobe && prev_strobe)
      begin
        strobe_seen = 1'b1;
        if (pend)
        begin
          pend = 1'b0;
          xfer_val = m_sr;
        end
        else
        begin
          busy = 1'b0;
        end
      end
      if (sr_oe !== strobe_seen)
      begin
        report("sr_oe", 40'(strobe_seen), 40'(sr_oe));
      end
      if (chk_cnt > 0)
      begin
        chk_cnt--;
        if (chk_cnt == 0)
        begin
          if (led !== m_led)
          begin
            report("led", 40'(m_led), 40'(led));
          end
          if (spi_dev_ss_n !== expected_selects(m_mux))
          begin
            report("spi_dev_ss_n", 40'(expected_selects(m_mux)), 40'(spi_dev_ss_n));
          end
        end
      end
      // all writes should have drained by now
      if (final_chk && !final_done)
      begin
        final_done = 1'b1;
        if (busy)
        begin
          error_count++;
          $display("4094 transfers were still running at the end of the run");
        end
        else if (sr_written && (last_latched !== m_sr))
        begin
          report("sr_data final word", 40'(m_sr), 40'(last_latched));
        end
      end
    end
    prev_sclk = spi_sclk;
    prev_ss = spi_ss_n;
    prev_sr_clk = sr_clk;
    prev_strobe = sr_strobe;
  end

endmodule

/* verif/spi_target_chk.sv */
`timescale 1ns/1ns

module spi_target_chk (
  input logic cs,
  input logic rst_n,
  input logic wr_stb,
  input logic rd_stb,
  input logic spi_ss_n,
  input logic miso
);

  // failed assertions so far
  int assert_fails = 0;

  // a frame commits a write or requests a read but never both at once
  strobe_excl: assert property (@(posedge cs) disable iff (!rst_n) !(wr_stb && rd_stb))
    else
    begin
      $error("write and read strobes were high on the same cycle");
      assert_fails++;
    end

  // single-cycle handshakes
  wr_one_cycle: assert property (@(posedge cs) disable iff (!rst_n) wr_stb |=> !wr_stb)
    else
    begin
      $error("write strobe stayed high for more than one cycle");
      assert_fails++;
    end

  rd_one_cycle: assert property (@(posedge cs) disable iff (!rst_n) rd_stb |=> !rd_stb)
    else
    begin
      $error("read strobe stayed high for more than one cycle");
      assert_fails++;
    end

  // miso bus is shared with other targets
  // quiet while deselected and still quiet on the first cycle of a new frame
  miso_idle: assert property (@(posedge cs) disable iff (!rst_n) spi_ss_n |=> !miso)
    else
    begin
      $error("miso was high while deselected or at the start of a frame");
      assert_fails++;
    end

endmodule

bind spi_target spi_target_chk spi_target_chk_inst (
  .cs       (cs),
  .rst_n    (rst_n),
  .wr_stb   (bus.wr_stb),
  .rd_stb   (bus.rd_stb),
  .spi_ss_n (spi_ss_n),
  .miso     (miso)
);

/* hdl/board_ctrl_top.sv */
`timescale 1ns/1ns

module board_ctrl_top #(
  // downstream SPI chip selects
  parameter int N_DEV = 4,
  // system clocks per half period of the 4094 shift clock
  parameter int SR_DIV = 4
) (
  input  logic cs,
  input  logic rst_n,
  input  logic spi_sclk,
  input  logic spi_ss_n,
  input  logic mosi,
  output logic miso,
  output logic [23:0] led,
  output logic [N_DEV-1:0] spi_dev_ss_n,
  output logic sr_clk,
  output logic sr_data,
  output logic sr_strobe,
  output logic sr_oe
);

  logic [23:0] sr_value;
  logic sr_load;

  regbus_if regbus_inst ();

  spi_target spi_target_inst (
    .cs       (cs),
    .rst_n    (rst_n),
    .spi_sclk (spi_sclk),
    .spi_ss_n (spi_ss_n),
    .mosi     (mosi),
    .miso     (miso),
    .bus      (regbus_inst.target)
  );

  reg_bank #(
    .N_DEV (N_DEV)
  ) reg_bank_inst (
    .cs           (cs),
    .rst_n        (rst_n),
    .bus          (regbus_inst.bank),
    .led          (led),
    .spi_dev_ss_n (spi_dev_ss_n),
    .sr_value     (sr_value),
    .sr_load      (sr_load)
  );

  // 4094 chain, three chips deep
  sr4094_driver #(
    .SR_DIV (SR_DIV)
  ) sr4094_driver_inst (
    .cs        (cs),
    .rst_n     (rst_n),
    .sr_value  (sr_value),
    .sr_load   (sr_load),
    .sr_clk    (sr_clk),
    .sr_data   (sr_data),
    .sr_strobe (sr_strobe),
    .sr_oe     (sr_oe)
  );

endmodule

/* hdl/sr4094_driver.sv */
`timescale 1ns/1ns

module sr4094_driver #(
  parameter int SR_DIV = 4
) (
  input  logic cs,
  input  logic rst_n,
  input  logic [regbank_pkg::DATA_W-1:0] sr_value,
  input  logic sr_load,
  output logic sr_clk,
  output logic sr_data,
  output logic sr_strobe,
  output logic sr_oe
);

  localparam int DIV_W = (SR_DIV > 1) ? $clog2(SR_DIV) : 1;
  localparam int BIT_W = $clog2(regbank_pkg::DATA_W);

  localparam logic [1:0] ST_IDLE = 2'd0;
  localparam logic [1:0] ST_SHIFT = 2'd1;
  localparam logic [1:0] ST_STROBE = 2'd2;

  logic [1:0] state;
  logic [DIV_W-1:0] div_cnt;
  logic [BIT_W-1:0] bit_cnt;
  // a load arrived while a transfer was running
  logic pending;
  logic [regbank_pkg::DATA_W-1:0] shreg;

  always_ff @(posedge cs)
  begin
    if (!rst_n)
    begin
      state <= ST_IDLE;
      div_cnt <= '0;
      bit_cnt <= '0;
      pending <= 1'b0;
      sr_clk <= 1'b0;
      sr_strobe <= 1'b0;
      sr_oe <= 1'b0;
    end
    else
    begin
      case (state)
        ST_IDLE:
        begin
          // register already holds the newest value for a pending load
          if (sr_load || pending)
          begin
            shreg <= sr_value;
            pending <= 1'b0;
            div_cnt <= '0;
            bit_cnt <= '0;
            sr_clk <= 1'b0;
            state <= ST_SHIFT;
          end
        end
        ST_SHIFT:
        begin
          div_cnt <= div_cnt + 1'b1;
          if (div_cnt == DIV_W'(SR_DIV - 1))
          begin
            div_cnt <= '0;
            if (!sr_clk)
            begin
              // data has been stable for a full low phase
              sr_clk <= 1'b1;
            end
            else
            begin
              sr_clk <= 1'b0;
              shreg <= shreg << 1;
              if (bit_cnt == BIT_W'(regbank_pkg::DATA_W - 1))
              begin
                sr_strobe <= 1'b1;
                state <= ST_STROBE;
              end
              else
              begin
                bit_cnt <= bit_cnt + 1'b1;
              end
            end
          end
        end
        ST_STROBE:
        begin
          div_cnt <= div_cnt + 1'b1;
          if (div_cnt == DIV_W'(SR_DIV - 1))
          begin
            div_cnt <= '0;
            sr_strobe <= 1'b0;
            // outputs enabled once the chain holds valid data
            sr_oe <= 1'b1;
            state <= ST_IDLE;
          end
        end
        default:
        begin
          state <= ST_IDLE;
        end
      endcase
      if (sr_load && (state != ST_IDLE))
      begin
        pending <= 1'b1;
      end
    end
  end

  // data only driven during the shift phase
  assign sr_data = (state == ST_SHIFT) & shreg[regbank_pkg::DATA_W-1];

endmodule

/* hdl/reg_bank.sv */
`timescale 1ns/1ns

module reg_bank #(
  parameter int N_DEV = 4
) (
  input  logic cs,
  input  logic rst_n,
  regbus_if.bank bus,
  output logic [regbank_pkg::DATA_W-1:0] led,
  output logic [N_DEV-1:0] spi_dev_ss_n,
  output logic [regbank_pkg::DATA_W-1:0] sr_value,
  output logic sr_load
);

  logic [regbank_pkg::DATA_W-1:0] spi_mux;

  // register writes, unknown addresses fall through
  always_ff @(posedge cs)
  begin
    if (!rst_n)
    begin
      led <= regbank_pkg::LED_RESET;
      spi_mux <= '0;
      sr_value <= '0;
      sr_load <= 1'b0;
    end
    else
    begin
      sr_load <= 1'b0;
      if (bus.wr_stb)
      begin
        case (bus.addr)
          regbank_pkg::ADDR_LED:
          begin
            led <= bus.wdata;
          end
          regbank_pkg::ADDR_SPI_MUX:
          begin
            spi_mux <= bus.wdata;
          end
          regbank_pkg::ADDR_4094:
          begin
            sr_value <= bus.wdata;
            // driver sees the new value together with the strobe
            sr_load <= 1'b1;
          end
          default:
          begin
          end
        endcase
      end
    end
  end

  // read data, held until the next request
  always_ff @(posedge cs)
  begin
    if (bus.rd_stb)
    begin
      case (bus.addr)
        regbank_pkg::ADDR_LED:     bus.rdata <= led;
        regbank_pkg::ADDR_SPI_MUX: bus.rdata <= spi_mux;
        regbank_pkg::ADDR_4094:    bus.rdata <= sr_value;
        default:                   bus.rdata <= regbank_pkg::UNMAPPED_READ;
      endcase
    end
  end

  // mux value n selects device n-1, zero or out of range selects none
  // registered so the external selects never glitch
  always_ff @(posedge cs)
  begin
    if (!rst_n)
    begin
      spi_dev_ss_n <= '1;
    end
    else
    begin
      for (int i = 0; i < N_DEV; i++)
      begin
        spi_dev_ss_n[i] <= (spi_mux != regbank_pkg::DATA_W'(i + 1));
      end
    end
  end

endmodule

/* hdl/spi_target.sv */
`timescale 1ns/1ns

module spi_target (
  input  logic cs,
  input  logic rst_n,
  input  logic spi_sclk,
  input  logic spi_ss_n,
  input  logic mosi,
  output logic miso,
  regbus_if.target bus
);

  // wide enough to hold FRAME_BITS, saturates above it
  localparam int CNT_W = $clog2(regbank_pkg::FRAME_BITS + 1);
  // bit count at the falling edge that opens the data phase
  localparam int TX_LOAD_BIT = regbank_pkg::FRAME_BITS - regbank_pkg::DATA_W;

  // two sync flops plus one history flop for edge detection
  logic [2:0] sclk_sync;
  logic [2:0] ss_sync;
  logic [1:0] mosi_sync;
  logic sclk_rise;
  logic sclk_fall;
  logic ss_rise;
  logic ss_fall;
  logic frame_act;

  regbank_pkg::frame_u frame;
  logic [CNT_W-1:0] bit_cnt;
  // pulses the cycle after the eighth bit is shifted in
  logic hdr_done;
  logic is_read;
  logic [regbank_pkg::DATA_W-1:0] tx_shift;

  always_ff @(posedge cs)
  begin
    if (!rst_n)
    begin
      sclk_sync <= '0;
      // select idles high
      ss_sync <= '1;
      mosi_sync <= '0;
    end
    else
    begin
      sclk_sync <= {sclk_sync[1:0], spi_sclk};
      ss_sync <= {ss_sync[1:0], spi_ss_n};
      mosi_sync <= {mosi_sync[0], mosi};
    end
  end

  assign sclk_rise = sclk_sync[1] & ~sclk_sync[2];
  assign sclk_fall = ~sclk_sync[1] & sclk_sync[2];
  assign ss_rise = ss_sync[1] & ~ss_sync[2];
  assign ss_fall = ~ss_sync[1] & ss_sync[2];
  assign frame_act = ~ss_sync[1];

  // receive shifter, mosi sampled on rising sclk
  always_ff @(posedge cs)
  begin
    if (sclk_rise && frame_act)
    begin
      frame.raw <= {frame.raw[regbank_pkg::FRAME_BITS-2:0], mosi_sync[1]};
    end
  end

  // bit counter and header tracking, restarted by each new select
  always_ff @(posedge cs)
  begin
    if (!rst_n)
    begin
      bit_cnt <= '0;
      hdr_done <= 1'b0;
      is_read <= 1'b0;
    end
    else if (ss_fall)
    begin
      bit_cnt <= '0;
      hdr_done <= 1'b0;
      is_read <= 1'b0;
    end
    else
    begin
      hdr_done <= 1'b0;
      if (sclk_rise && frame_act)
      begin
        if (bit_cnt != '1)
        begin
          bit_cnt <= bit_cnt + 1'b1;
        end
        hdr_done <= (bit_cnt == CNT_W'(regbank_pkg::HDR_BITS - 1));
      end
      // first bit of the frame has now moved up to the top of the header
      if (hdr_done)
      begin
        is_read <= frame.raw[regbank_pkg::HDR_BITS-1];
      end
    end
  end

  // strobes to the bank
  always_ff @(posedge cs)
  begin
    if (!rst_n)
    begin
      bus.rd_stb <= 1'b0;
      bus.wr_stb <= 1'b0;
    end
    else
    begin
      bus.rd_stb <= hdr_done & frame.raw[regbank_pkg::HDR_BITS-1];
      // commit only a complete write frame
      bus.wr_stb <= ss_rise && (bit_cnt == CNT_W'(regbank_pkg::FRAME_BITS))
                    && !frame.f.rd;
    end
  end

  // address and data travel with the strobes
  always_ff @(posedge cs)
  begin
    if (hdr_done)
    begin
      bus.addr <= frame.raw[regbank_pkg::HDR_BITS-2:0];
    end
    else if (ss_rise)
    begin
      bus.addr <= frame.f.addr;
      bus.wdata <= frame.f.data;
    end
  end

  // transmit shifter, advanced on falling sclk
  always_ff @(posedge cs)
  begin
    if (!rst_n)
    begin
      tx_shift <= '0;
    end
    else if (!frame_act)
    begin
      tx_shift <= '0;
    end
    else if (sclk_fall)
    begin
      if (bit_cnt == CNT_W'(TX_LOAD_BIT))
      begin
        // write frames send zeros in the data phase
        tx_shift <= is_read ? bus.rdata : '0;
      end
      else if (bit_cnt > CNT_W'(TX_LOAD_BIT))
      begin
        tx_shift <= tx_shift << 1;
      end
    end
  end

  // raw pin keeps miso quiet before the synchronizer catches up
  assign miso = tx_shift[regbank_pkg::DATA_W-1] & ~spi_ss_n;

endmodule

/* hdl/regbus_if.sv */
`timescale 1ns/1ns

interface regbus_if;

  // one-cycle write strobe, addr and wdata valid on the same cycle
  logic wr_stb;
  // one-cycle read request, rdata answers on the next cycle
  logic rd_stb;
  logic [regbank_pkg::ADDR_W-1:0] addr;
  logic [regbank_pkg::DATA_W-1:0] wdata;
  // held by the bank until the next read request
  logic [regbank_pkg::DATA_W-1:0] rdata;

  modport target (
    output wr_stb,
    output rd_stb,
    output addr,
    output wdata,
    input  rdata
  );

  modport bank (
    input  wr_stb,
    input  rd_stb,
    input  addr,
    input  wdata,
    output rdata
  );

endinterface

/* hdl/regbank_pkg.sv */
package regbank_pkg;

  // frame layout, MSB first on the wire
  localparam int FRAME_BITS = 40;
  // read flag plus register address
  localparam int HDR_BITS = 8;
  localparam int PAD_BITS = 8;
  localparam int ADDR_W = HDR_BITS - 1;
  localparam int DATA_W = 24;

  // register map
  localparam logic [ADDR_W-1:0] ADDR_LED = 7'd7;
  localparam logic [ADDR_W-1:0] ADDR_SPI_MUX = 7'd8;
  localparam logic [ADDR_W-1:0] ADDR_4094 = 7'd9;

  // alternating pattern, easy to spot on the LEDs after power up
  localparam logic [DATA_W-1:0] LED_RESET = 24'haaaaaa;
  // read-back value for any address outside the map
  localparam logic [DATA_W-1:0] UNMAPPED_READ = 24'h0f0f0f;

  // field view of a complete frame
  typedef struct packed {
    // 1 requests a read, 0 a write
    logic rd;
    logic [ADDR_W-1:0] addr;
    // gives the bank time to fetch read data
    logic [PAD_BITS-1:0] pad;
    logic [DATA_W-1:0] data;
  } frame_fields_t;

  // raw view is what the shift register fills
  typedef union packed {
    logic [FRAME_BITS-1:0] raw;
    frame_fields_t f;
  } frame_u;

endpackage
